// File: source/ice_pkg.sv
package ice_pkg;

	// Command letters known to the decoder
	typedef enum logic [3:0] {
		CMD_PINT_W0 = 4'd0,
		CMD_PINT_W1 = 4'd1,
		CMD_NONE    = 4'hf
	} cmd_e;

	// Longest write frame payload in bytes
	localparam int PINT_MAX_BYTES = 8;

	// One received character after classification
	typedef struct packed {
		logic       is_hex;
		logic [3:0] hex;
		logic       is_cmd;
		cmd_e       cmd;
		logic       is_eol;
	} decoded_char_t;

	// PINT pins driven by the master
	typedef struct packed {
		logic wrreq;
		logic wrdata;
		logic pclk;
		logic resetn;
		logic rdreq;
	} pint_out_t;

	// PINT pins driven by the test chip
	typedef struct packed {
		logic rdrdy;
		logic rddata;
	} pint_in_t;

endpackage

// File: source/uart.sv
module uart #(
	parameter int UART_DIVIDE = 174
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx_in,
	input  logic       tx_latch,
	input  logic [7:0] tx_data,
	output logic       tx_out,
	output logic       tx_empty,
	output logic [7:0] rx_data,
	output logic       rx_latch
);
	localparam int CW = $clog2(UART_DIVIDE + 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t rx_state;
	logic [1:0] rx_sync;
	logic rx_s;
	logic [CW-1:0] rx_cnt;
	logic [2:0] rx_bit;

	logic [9:0] tx_shift;
	logic [CW-1:0] tx_cnt;
	logic [3:0] tx_bits;

	assign rx_s = rx_sync[1];

	// Receiver, bits sampled at their middle
	always_ff @(posedge clk) begin
		rx_sync <= {rx_sync[0], rx_in};
		rx_latch <= 1'b0;
		if (reset) begin
			rx_sync <= 2'b11;
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
		end else begin
			case (rx_state)
				RX_IDLE: begin
					if (!rx_s) begin
						rx_state <= RX_START;
						rx_cnt <= CW'(UART_DIVIDE / 2);
					end
				end
				RX_START: begin
					if (rx_cnt != '0) begin
						rx_cnt <= rx_cnt - 1'b1;
					end else if (!rx_s) begin
						rx_state <= RX_DATA;
						rx_cnt <= CW'(UART_DIVIDE - 1);
						rx_bit <= '0;
					end else begin
						// Glitch, not a real start bit
						rx_state <= RX_IDLE;
					end
				end
				RX_DATA: begin
					if (rx_cnt != '0) begin
						rx_cnt <= rx_cnt - 1'b1;
					end else begin
						// LSB arrives first
						rx_data <= {rx_s, rx_data[7:1]};
						rx_cnt <= CW'(UART_DIVIDE - 1);
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end
				end
				default: begin
					if (rx_cnt != '0) begin
						rx_cnt <= rx_cnt - 1'b1;
					end else begin
						rx_state <= RX_IDLE;
						rx_latch <= rx_s;
					end
				end
			endcase
		end
	end

	// Transmitter: start bit, 8 data bits, stop bit
	always_ff @(posedge clk) begin
		if (reset) begin
			tx_shift <= '1;
			tx_empty <= 1'b1;
			tx_cnt <= '0;
			tx_bits <= '0;
		end else if (tx_empty) begin
			if (tx_latch) begin
				tx_shift <= {1'b1, tx_data, 1'b0};
				tx_empty <= 1'b0;
				tx_cnt <= CW'(UART_DIVIDE - 1);
				tx_bits <= '0;
			end
		end else if (tx_cnt != '0) begin
			tx_cnt <= tx_cnt - 1'b1;
		end else begin
			tx_shift <= {1'b1, tx_shift[9:1]};
			tx_cnt <= CW'(UART_DIVIDE - 1);
			tx_bits <= tx_bits + 1'b1;
			if (tx_bits == 4'd9)
				tx_empty <= 1'b1;
		end
	end

	assign tx_out = tx_shift[0];

endmodule

// File: source/character_decoder.sv
module character_decoder (
	input  logic [7:0]             in_char,
	input  logic                   in_char_valid,
	output ice_pkg::decoded_char_t dec
);
	import ice_pkg::*;

	always_comb begin
		dec = '{is_hex: 1'b0, hex: 4'd0, is_cmd: 1'b0, cmd: CMD_NONE, is_eol: 1'b0};
		if (in_char_valid) begin
			case (in_char) inside
				["0":"9"]: begin
					dec.is_hex = 1'b1;
					dec.hex = in_char[3:0];
				end
				// Low nibble of 'a'..'f' and 'A'..'F' runs 1..6
				["a":"f"], ["A":"F"]: begin
					dec.is_hex = 1'b1;
					dec.hex = in_char[3:0] + 4'd9;
				end
				"p": begin
					dec.is_cmd = 1'b1;
					dec.cmd = CMD_PINT_W0;
				end
				"q": begin
					dec.is_cmd = 1'b1;
					dec.cmd = CMD_PINT_W1;
				end
				8'h0a: begin
					dec.is_eol = 1'b1;
				end
				default: begin
					dec.is_eol = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: source/fifo.sv
module fifo #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] in,
	input  logic       in_latch,
	input  logic       out_latch,
	output logic [7:0] out,
	output logic       out_valid
);
	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

	logic [7:0] mem [DEPTH];
	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic [FIFO_DEPTH_LOG2:0] count;
	logic push;
	logic pop;

	// Writes into a full buffer are lost
	assign push = in_latch && (count != (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
	assign pop = out_latch && out_valid;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + push - pop;
		end
	end

	// Head word visible without a pop
	assign out = mem[rd_ptr];
	assign out_valid = (count != '0);

endmodule

// File: source/pint_int.sv
module pint_int #(
	parameter int PINT_HALF_PERIOD = 4
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               tx_req,
	input  logic               tx_cmd_type,
	input  logic [7:0]         tx_char,
	input  logic               tx_char_latch,
	input  ice_pkg::pint_in_t  pins_in,
	output logic               busy,
	output logic               rx_latch,
	output logic [7:0]         rx_data,
	output ice_pkg::pint_out_t pins
);
	import ice_pkg::*;

	localparam int HW = $clog2(PINT_HALF_PERIOD + 1);
	localparam int IW = $clog2(PINT_MAX_BYTES);
	localparam int SR_W = 8 * PINT_MAX_BYTES + 1;
	localparam int BW = $clog2(SR_W + 1);

	typedef enum logic [1:0] {P_IDLE, P_WRITE, P_READ, P_DONE} pint_state_t;

	pint_state_t state;
	logic [0:PINT_MAX_BYTES-1][7:0] wbuf;
	logic [IW:0] wr_cnt;
	logic [SR_W-1:0] frame_sr;
	logic [BW-1:0] bits_left;
	logic [HW-1:0] hp_cnt;
	logic pclk_r;
	logic wrreq_r;
	logic rdreq_r;
	logic resetn_r;
	logic tick;
	logic flush;
	logic push;

	// tx_req together with tx_char_latch empties the buffer of an abandoned line
	assign flush = tx_req && tx_char_latch;
	assign push = tx_char_latch && !tx_req && (wr_cnt < (IW + 1)'(PINT_MAX_BYTES));
	assign tick = (state == P_WRITE || state == P_READ) &&
		(hp_cnt == HW'(PINT_HALF_PERIOD - 1));
	assign busy = (state != P_IDLE);

	always_ff @(posedge clk) begin
		if (push)
			wbuf[wr_cnt[IW-1:0]] <= tx_char;
	end

	always_ff @(posedge clk) begin
		resetn_r <= !reset;
	end

	always_ff @(posedge clk) begin
		rx_latch <= 1'b0;
		if (reset) begin
			state <= P_IDLE;
			wr_cnt <= '0;
			bits_left <= '0;
			hp_cnt <= '0;
			pclk_r <= 1'b0;
			wrreq_r <= 1'b0;
			rdreq_r <= 1'b0;
		end else begin
			if (flush)
				wr_cnt <= '0;
			else if (push)
				wr_cnt <= wr_cnt + 1'b1;

			case (state)
				P_IDLE: begin
					hp_cnt <= '0;
					if (tx_req && !tx_char_latch) begin
						// Type bit goes out first, then byte 0 MSB first
						state <= P_WRITE;
						wrreq_r <= 1'b1;
						frame_sr <= {tx_cmd_type, wbuf};
						bits_left <= BW'({wr_cnt, 3'b000}) + BW'(1);
					end else if (pins_in.rdrdy) begin
						state <= P_READ;
						rdreq_r <= 1'b1;
						bits_left <= BW'(8);
					end
				end
				P_WRITE, P_READ: begin
					if (!tick) begin
						hp_cnt <= hp_cnt + 1'b1;
					end else begin
						hp_cnt <= '0;
						pclk_r <= !pclk_r;
						if (!pclk_r) begin
							// Rising edge, target and master both sample here
							bits_left <= bits_left - 1'b1;
							if (rdreq_r)
								rx_data <= {rx_data[6:0], pins_in.rddata};
						end else if (bits_left == '0) begin
							state <= P_DONE;
						end else begin
							frame_sr <= frame_sr << 1;
						end
					end
				end
				default: begin
					state <= P_IDLE;
					wrreq_r <= 1'b0;
					rdreq_r <= 1'b0;
					if (rdreq_r)
						rx_latch <= 1'b1;
					else
						wr_cnt <= '0;
				end
			endcase
		end
	end

	always_comb begin
		pins.wrreq = wrreq_r;
		pins.wrdata = wrreq_r & frame_sr[SR_W-1];
		pins.pclk = pclk_r;
		pins.resetn = resetn_r;
		pins.rdreq = rdreq_r;
	end

endmodule

// File: source/ice_controller.sv
module ice_controller #(
	parameter int UART_DIVIDE      = 174,
	parameter int FIFO_DEPTH_LOG2  = 4,
	parameter int PINT_HALF_PERIOD = 4
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               uart_rx,
	input  ice_pkg::pint_in_t  pint_in,
	output logic               uart_tx,
	output ice_pkg::pint_out_t pint_out
);
	import ice_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_COLLECT, S_SEND} cmd_state_t;
	typedef enum logic [1:0] {R_IDLE, R_HEAD, R_DATA, R_EOL} reply_state_t;

	logic [7:0] uart_rx_data;
	logic [7:0] uart_tx_data;
	logic uart_rx_latch;
	logic uart_tx_latch;
	logic uart_tx_empty;
	decoded_char_t dec;

	logic pint_busy;
	logic pint_tx_req;
	logic pint_tx_cmd_type;
	logic pint_tx_char_latch;
	logic pint_rx_latch;
	logic [7:0] pint_rx_data;
	logic [7:0] fifo_data;
	logic fifo_pop;
	logic fifo_valid;

	cmd_state_t cmd_state;
	cmd_state_t cmd_next;
	cmd_e last_cmd;
	logic cmd_pending;
	logic [3:0] hex_sr;
	logic nib_odd;
	logic [3:0] byte_cnt;
	logic shift_hex;
	logic sr_clear;

	reply_state_t reply_state;
	reply_state_t reply_next;

	uart #(.UART_DIVIDE(UART_DIVIDE)) u_uart (
		.clk(clk),
		.reset(reset),
		.rx_in(uart_rx),
		.tx_latch(uart_tx_latch),
		.tx_data(uart_tx_data),
		.tx_out(uart_tx),
		.tx_empty(uart_tx_empty),
		.rx_data(uart_rx_data),
		.rx_latch(uart_rx_latch)
	);

	character_decoder u_character_decoder (
		.in_char(uart_rx_data),
		.in_char_valid(uart_rx_latch),
		.dec(dec)
	);

	fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_fifo (
		.clk(clk),
		.reset(reset),
		.in(pint_rx_data),
		.in_latch(pint_rx_latch),
		.out_latch(fifo_pop),
		.out(fifo_data),
		.out_valid(fifo_valid)
	);

	pint_int #(.PINT_HALF_PERIOD(PINT_HALF_PERIOD)) u_pint_int (
		.clk(clk),
		.reset(reset),
		.tx_req(pint_tx_req),
		.tx_cmd_type(pint_tx_cmd_type),
		.tx_char({hex_sr, dec.hex}),
		.tx_char_latch(pint_tx_char_latch),
		.pins_in(pint_in),
		.busy(pint_busy),
		.rx_latch(pint_rx_latch),
		.rx_data(pint_rx_data),
		.pins(pint_out)
	);

	// Command state machine
	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_state <= S_IDLE;
			last_cmd <= CMD_NONE;
			cmd_pending <= 1'b0;
			nib_odd <= 1'b0;
			byte_cnt <= '0;
		end else if (dec.is_cmd) begin
			// A new command restarts the line
			cmd_state <= S_IDLE;
			last_cmd <= dec.cmd;
			cmd_pending <= 1'b1;
			nib_odd <= 1'b0;
			byte_cnt <= '0;
		end else begin
			cmd_state <= cmd_next;
			if (cmd_state == S_IDLE)
				cmd_pending <= 1'b0;
			if (shift_hex) begin
				hex_sr <= dec.hex;
				nib_odd <= !nib_odd;
			end
			if (pint_tx_char_latch)
				byte_cnt <= byte_cnt + 1'b1;
			if (sr_clear) begin
				nib_odd <= 1'b0;
				byte_cnt <= '0;
			end
		end
	end

	always_comb begin
		cmd_next = cmd_state;
		shift_hex = 1'b0;
		sr_clear = 1'b0;
		pint_tx_req = 1'b0;
		pint_tx_char_latch = 1'b0;
		pint_tx_cmd_type = (last_cmd == CMD_PINT_W1);
		case (cmd_state)
			S_IDLE: begin
				if (cmd_pending && last_cmd != CMD_NONE)
					cmd_next = S_COLLECT;
			end
			S_COLLECT: begin
				if (dec.is_hex) begin
					shift_hex = 1'b1;
					// Second nibble of a pair completes a byte
					pint_tx_char_latch = nib_odd && (byte_cnt < 4'(PINT_MAX_BYTES));
				end else if (dec.is_eol) begin
					cmd_next = S_SEND;
				end
			end
			S_SEND: begin
				if (byte_cnt == '0) begin
					sr_clear = 1'b1;
					cmd_next = S_IDLE;
				end else if (!pint_busy) begin
					pint_tx_req = 1'b1;
					sr_clear = 1'b1;
					cmd_next = S_IDLE;
				end
			end
			default: begin
				cmd_next = S_IDLE;
			end
		endcase
		// Bytes of an abandoned line are dropped from the PINT buffer
		if (dec.is_cmd && byte_cnt != '0) begin
			pint_tx_req = 1'b1;
			pint_tx_char_latch = 1'b1;
		end
	end

	// Reply state machine: 'a', read bytes, newline
	always_ff @(posedge clk) begin
		if (reset)
			reply_state <= R_IDLE;
		else
			reply_state <= reply_next;
	end

	always_comb begin
		reply_next = reply_state;
		uart_tx_latch = 1'b0;
		uart_tx_data = 8'h00;
		fifo_pop = 1'b0;
		case (reply_state)
			R_IDLE: begin
				if (pint_rx_latch)
					reply_next = R_HEAD;
			end
			R_HEAD: begin
				uart_tx_latch = uart_tx_empty;
				uart_tx_data = "a";
				if (uart_tx_empty)
					reply_next = R_DATA;
			end
			R_DATA: begin
				uart_tx_latch = uart_tx_empty & fifo_valid;
				uart_tx_data = fifo_data;
				fifo_pop = uart_tx_latch;
				if (!fifo_valid)
					reply_next = R_EOL;
			end
			default: begin
				uart_tx_latch = uart_tx_empty;
				uart_tx_data = 8'h0a;
				if (uart_tx_empty)
					reply_next = R_IDLE;
			end
		endcase
	end

endmodule

// File: tb/ice_controller_assertions.sv
module ice_controller_assertions (
	input logic               clk,
	input logic               reset,
	input logic               uart_tx,
	input ice_pkg::pint_out_t pint_out
);
	timeunit 1ns;
	timeprecision 100ps;

	import ice_pkg::*;

	// Number of failed assertions
	int fail_count = 0;

	// pclk runs only inside a write frame or a read transfer
	pclk_in_transfer: assert property (@(posedge clk) disable iff (reset)
		$changed(pint_out.pclk) |-> ($past(pint_out.wrreq) || $past(pint_out.rdreq)))
		else begin
			fail_count++;
			$error("pclk toggled outside a transfer");
		end

	// Write and read never share the bus
	wr_rd_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(pint_out.wrreq && pint_out.rdreq))
		else begin
			fail_count++;
			$error("wrreq and rdreq high together");
		end

	// UART line idles during reset
	tx_idle_in_reset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> uart_tx)
		else begin
			fail_count++;
			$error("uart_tx low during reset");
		end

endmodule

bind ice_controller ice_controller_assertions u_ice_controller_assertions (
	.clk(clk),
	.reset(reset),
	.uart_tx(uart_tx),
	.pint_out(pint_out)
);

// File: tb/tb_ice_controller.sv
module tb_ice_controller;
	timeunit 1ns;
	timeprecision 100ps;

	import ice_pkg::*;

	localparam int UART_DIVIDE = 16;
	localparam int HALF = 4;
	localparam int CLK_NS = 8;
	localparam int CHAR_CYCLES = 11 * UART_DIVIDE;
	localparam int FRAME_CYCLES = (1 + 8 * PINT_MAX_BYTES) * 2 * HALF + 16;
	localparam int N_LINES = 12;
	localparam int LINE_CHARS = 26;
	localparam int N_BURSTS = 4;
	localparam longint WATCHDOG_NS = (longint'(N_LINES * LINE_CHARS + N_BURSTS * 10) * CHAR_CYCLES
		+ (N_LINES + N_BURSTS) * 3 * FRAME_CYCLES + 2000) * CLK_NS;

	typedef logic [7:0] frame_bytes_t [PINT_MAX_BYTES];

	logic clk = 1'b0;
	logic reset;
	logic uart_rx;
	logic uart_tx;
	logic rd_rdy;
	logic rd_data;
	pint_in_t pint_in;
	pint_out_t pint_out;

	logic [31:0] lfsr_state = 32'h081d7ee9;
	int n_frame_err = 0;
	int n_byte_err = 0;
	int n_pin_err = 0;
	int n_other_err = 0;

	// Expected write frames with their bytes stored flat
	logic exp_type_q[$];
	int exp_len_q[$];
	logic [7:0] exp_byte_q[$];
	int frames_expected = 0;
	int frames_seen = 0;

	// PINT target state
	logic pclk_q = 1'b0;
	logic wrreq_q = 1'b0;
	logic [64:0] wr_bits;
	int wr_nbits;
	logic [7:0] rd_q[$];
	logic rd_active;
	int rd_idx;
	logic [7:0] reply_q[$];

	assign pint_in = '{rdrdy: rd_rdy, rddata: rd_data};

	ice_controller #(
		.UART_DIVIDE(UART_DIVIDE),
		.FIFO_DEPTH_LOG2(4),
		.PINT_HALF_PERIOD(HALF)
	) u_ice_controller (
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.pint_in(pint_in),
		.uart_tx(uart_tx),
		.pint_out(pint_out)
	);

	always #(CLK_NS / 2) clk = !clk;

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp) begin
			n_byte_err++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_pins(input pint_out_t exp, input pint_out_t got);
		if (got !== exp) begin
			n_pin_err++;
			$display("** Error at %0t: pint_out expected %b, got %b", $time, exp, got);
		end
	endtask

	task automatic check_frame(input logic exp_type, input logic got_type, input int n,
		input frame_bytes_t exp_b, input frame_bytes_t got_b);
		int i;
		if (got_type !== exp_type) begin
			n_frame_err++;
			$display("** Error at %0t: frame type expected %b, got %b", $time, exp_type, got_type);
		end
		for (i = 0; i < n; i++) begin
			if (got_b[i] !== exp_b[i]) begin
				n_frame_err++;
				$display("** Error at %0t: frame byte %0d expected %h, got %h",
					$time, i, exp_b[i], got_b[i]);
			end
		end
	endtask

	task automatic close_frame();
		logic etype;
		int elen;
		int i;
		logic [64:0] t;
		frame_bytes_t eb;
		frame_bytes_t gb;
		frames_seen++;
		if (exp_type_q.size() == 0) begin
			n_other_err++;
			$display("PINT write frame at %0t arrived when none was expected", $time);
			return;
		end
		etype = exp_type_q.pop_front();
		elen = exp_len_q.pop_front();
		for (i = 0; i < PINT_MAX_BYTES; i++) begin
			eb[i] = 8'h00;
			gb[i] = 8'h00;
		end
		for (i = 0; i < elen; i++)
			eb[i] = exp_byte_q.pop_front();
		if (wr_nbits != 1 + 8 * elen) begin
			n_other_err++;
			$display("PINT write frame at %0t has %0d bits instead of %0d",
				$time, wr_nbits, 1 + 8 * elen);
		end else begin
			for (i = 0; i < elen; i++) begin
				t = wr_bits >> (8 * (elen - 1 - i));
				gb[i] = t[7:0];
			end
			check_frame(etype, wr_bits[8 * elen], elen, eb, gb);
		end
	endtask

	// PINT target samples writes and sources read bits
	always @(posedge clk) begin
		pclk_q <= pint_out.pclk;
		wrreq_q <= pint_out.wrreq;
		if (reset) begin
			wr_nbits <= 0;
			rd_active <= 1'b0;
			rd_rdy <= 1'b0;
			rd_data <= 1'b0;
		end else begin
			if (pint_out.wrreq && pint_out.pclk && !pclk_q) begin
				wr_bits <= {wr_bits[63:0], pint_out.wrdata};
				wr_nbits <= wr_nbits + 1;
			end
			if (wrreq_q && !pint_out.wrreq) begin
				close_frame();
				wr_nbits <= 0;
			end
			if (!rd_active && rd_q.size() != 0) begin
				rd_active <= 1'b1;
				rd_rdy <= 1'b1;
				rd_idx = 0;
				rd_data <= rd_q[0][7];
			end else if (rd_active && pint_out.rdreq && pint_out.pclk && !pclk_q) begin
				rd_idx++;
				if (rd_idx == 8 * rd_q.size()) begin
					rd_rdy <= 1'b0;
					rd_active <= 1'b0;
					rd_q.delete();
				end else begin
					rd_data <= rd_q[rd_idx / 8][7 - rd_idx % 8];
				end
			end
		end
	end

	// UART receiver model on uart_tx
	initial begin
		logic [7:0] b;
		forever begin
			@(posedge clk);
			if (!reset && uart_tx === 1'b0) begin
				repeat (UART_DIVIDE / 2) @(posedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (UART_DIVIDE) @(posedge clk);
					b[i] = uart_tx;
				end
				repeat (UART_DIVIDE) @(posedge clk);
				if (uart_tx !== 1'b1) begin
					n_other_err++;
					$display("Missing stop bit on uart_tx at %0t", $time);
				end
				reply_q.push_back(b);
			end
		end
	end

	task automatic send_char(input logic [7:0] c);
		logic [9:0] bits;
		int i;
		bits = {1'b1, c, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			uart_rx <= bits[i];
			repeat (UART_DIVIDE - 1) @(posedge clk);
		end
		repeat (UART_DIVIDE) @(posedge clk);
	endtask

	function automatic logic [7:0] hex_char(input logic [3:0] nib, input logic upper);
		if (nib < 4'd10)
			return 8'h30 + nib;
		return (upper ? 8'h41 : 8'h61) + (nib - 4'd10);
	endfunction

	// Any character that is neither hex, a command nor a newline
	task automatic noise_char(output logic [7:0] c);
		logic [31:0] r;
		do begin
			r = random_bits(8);
			c = r[7:0];
		end while ((c >= "0" && c <= "9") || (c >= "a" && c <= "f") || (c >= "A" && c <= "F")
			|| c == "p" || c == "q" || c == 8'h0a);
	endtask

	task automatic send_nibbles(input int n_nib, input int n_noise, output logic [3:0] nibs [16]);
		logic [31:0] r;
		logic [7:0] c;
		int i;
		int left;
		left = n_noise;
		for (i = 0; i < n_nib; i++) begin
			r = random_bits(1);
			if (left > 0 && r[0]) begin
				noise_char(c);
				send_char(c);
				left--;
			end
			r = random_bits(5);
			nibs[i] = r[3:0];
			send_char(hex_char(r[3:0], r[4]));
		end
		for (i = 0; i < left; i++) begin
			noise_char(c);
			send_char(c);
		end
	endtask

	// Sends one line and waits for its frame or a quiet window
	task automatic send_line(input logic [7:0] cmd, input int n_nib, input int n_noise);
		logic [3:0] nibs [16];
		int n_bytes;
		int i;
		int cyc;
		send_char(cmd);
		send_nibbles(n_nib, n_noise, nibs);
		n_bytes = n_nib / 2;
		if (n_bytes > PINT_MAX_BYTES)
			n_bytes = PINT_MAX_BYTES;
		if (n_bytes > 0) begin
			exp_type_q.push_back(cmd == "q");
			exp_len_q.push_back(n_bytes);
			for (i = 0; i < n_bytes; i++)
				exp_byte_q.push_back({nibs[2 * i], nibs[2 * i + 1]});
			frames_expected++;
		end
		send_char(8'h0a);
		if (n_bytes > 0) begin
			cyc = 0;
			while (frames_seen < frames_expected && cyc < 2 * FRAME_CYCLES) begin
				@(posedge clk);
				cyc++;
			end
			if (frames_seen < frames_expected) begin
				n_other_err++;
				$display("PINT write frame for line %c did not arrive", cmd);
			end
		end else begin
			repeat (FRAME_CYCLES) @(posedge clk);
		end
	endtask

	task automatic read_burst(input int n);
		logic [7:0] bytes[$];
		logic [31:0] r;
		int i;
		int cyc;
		for (i = 0; i < n; i++) begin
			r = random_bits(8);
			bytes.push_back(r[7:0]);
		end
		rd_q = bytes;
		cyc = 0;
		while (reply_q.size() < n + 2 && cyc < (n + 3) * CHAR_CYCLES + n * FRAME_CYCLES) begin
			@(posedge clk);
			cyc++;
		end
		if (reply_q.size() < n + 2) begin
			n_other_err++;
			$display("Reply to a read burst of %0d bytes is incomplete", n);
			reply_q.delete();
		end else begin
			check_byte("reply header", "a", reply_q.pop_front());
			for (i = 0; i < n; i++)
				check_byte($sformatf("reply byte %0d", i), bytes[i], reply_q.pop_front());
			check_byte("reply newline", 8'h0a, reply_q.pop_front());
		end
		repeat (CHAR_CYCLES) @(posedge clk);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests completed");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic [31:0] r;
		int k;
		int n_assert_err;
		logic [3:0] dropped_nibs [16];
		reset = 1'b1;
		uart_rx = 1'b1;
		rd_rdy = 1'b0;
		rd_data = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		repeat (3) @(posedge clk);
		check_pins('{wrreq: 1'b0, wrdata: 1'b0, pclk: 1'b0, resetn: 1'b1, rdreq: 1'b0}, pint_out);
		if (uart_tx !== 1'b1) begin
			n_other_err++;
			$display("uart_tx is not idle high after reset");
		end

		for (k = 0; k < 4; k++) begin
			r = random_bits(3);
			send_line("p", 2 * (1 + r % 7), 0);
		end
		for (k = 0; k < 2; k++) begin
			r = random_bits(3);
			send_line("q", 2 * (1 + r % 7), 0);
		end
		send_line("q", 3, 0);
		send_line("p", 1, 0);
		r = random_bits(2);
		send_line("p", 8, 1 + r[1:0]);
		r = random_bits(2);
		send_line("q", 10, 1 + r[1:0]);

		// Abandoned lines where only the new command's frame goes out
		send_char("p");
		send_nibbles(5, 0, dropped_nibs);
		send_line("q", 6, 2);
		send_char("q");
		send_nibbles(1, 1, dropped_nibs);
		send_line("p", 4, 0);

		for (k = 0; k < N_BURSTS; k++) begin
			r = random_bits(3);
			read_burst(1 + r % 6);
		end

		if (exp_type_q.size() != 0) begin
			n_other_err++;
			$display("%0d expected PINT write frames never arrived", exp_type_q.size());
		end
		if (reply_q.size() != 0) begin
			n_other_err++;
			$display("%0d unexpected bytes left on uart_tx", reply_q.size());
		end
		n_assert_err = u_ice_controller.u_ice_controller_assertions.fail_count;
		$display("Errors: frame %0d, byte %0d, pins %0d, other %0d, assertions %0d",
			n_frame_err, n_byte_err, n_pin_err, n_other_err, n_assert_err);
		if (n_frame_err + n_byte_err + n_pin_err + n_other_err + n_assert_err == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: ice_controller.f
source/ice_pkg.sv
source/uart.sv
source/character_decoder.sv
source/fifo.sv
source/pint_int.sv
source/ice_controller.sv
tb/ice_controller_assertions.sv
tb/tb_ice_controller.sv

// File: Bender.yml
package:
  name: ice_controller

sources:
  - source/ice_pkg.sv
  - source/uart.sv
  - source/character_decoder.sv
  - source/fifo.sv
  - source/pint_int.sv
  - source/ice_controller.sv
  - target: test
    files:
      - tb/ice_controller_assertions.sv
      - tb/tb_ice_controller.sv
